// File: hdl/mul_pkg.sv
// shared lane state encoding and default sizes for the multiply unit
// sizes here are only defaults, the top level overrides them per instance

`default_nettype none

package mul_pkg;

  // ==========================================================================
  // lane FSM encoding
  // ==========================================================================

  // idle  waiting for a start strobe
  // calc  one set bit of b retired per cycle
  // done  product held until the collector acks
  typedef enum logic [1:0] {
    idle = 2'd0,
    calc = 2'd1,
    done = 2'd2
  } lane_state_t;

  // ==========================================================================
  // default sizes
  // ==========================================================================

  localparam int default_width     = 32;  // operand and product bits
  localparam int default_lanes     = 4;   // parallel multipliers
  localparam int default_tag_width = 4;   // request tag bits

endpackage

`default_nettype wire

// File: hdl/mul_dispatch.sv
// request dispatcher, one request per cycle at most, no back-pressure
// a request with no idle lane is lost and only counted in drop_count

`default_nettype none

module mul_dispatch #(
  parameter int width     = mul_pkg::default_width,
  parameter int lanes     = mul_pkg::default_lanes,
  parameter int tag_width = mul_pkg::default_tag_width
) (
  input  logic                 clk,
  input  logic                 reset,

  // request strobe from outside
  input  logic                 in_valid,
  input  logic [width-1:0]     in_a,
  input  logic [width-1:0]     in_b,
  input  logic [tag_width-1:0] in_tag,

  // lane handshake
  input  logic [lanes-1:0]     lane_idle,
  output logic [lanes-1:0]     start,
  output logic [width-1:0]     op_a,
  output logic [width-1:0]     op_b,
  output logic [tag_width-1:0] op_tag,

  output logic [7:0]           drop_count
);

  // ==========================================================================
  // lane selection
  // ==========================================================================

  logic [lanes-1:0] free;
  logic [lanes-1:0] pick;
  logic             any_free;
  logic             drop;

  // a lane started this cycle still shows idle until its FSM moves,
  // so mask it out here
  assign free     = lane_idle & ~start;

  // isolate lowest set bit, lowest index wins
  assign pick     = free & (~free + lanes'(1));
  assign any_free = |free;
  assign drop     = in_valid && !any_free;

  // ==========================================================================
  // registered start and operands
  // ==========================================================================

  always_ff @(posedge clk) begin
    if (reset) begin
      start <= '0;
    end else if (in_valid) begin
      start <= pick;
    end else begin
      start <= '0;
    end
  end

  // operands only move when a lane actually takes them
  always_ff @(posedge clk) begin
    if (in_valid && any_free) begin
      op_a   <= in_a;
      op_b   <= in_b;
      op_tag <= in_tag;
    end
  end

  // saturating drop counter
  always_ff @(posedge clk) begin
    if (reset) begin
      drop_count <= '0;
    end else if (drop && drop_count != 8'hff) begin
      drop_count <= drop_count + 8'd1;
    end
  end

  // ==========================================================================
  // checks
  // ==========================================================================

  // at most one lane per start, and only one that the lane reports idle
  start_onehot_idle_a : assert property (
    @(posedge clk) disable iff (reset)
    $onehot0(start) && ((start & ~lane_idle) == '0)
  );

endmodule

`default_nettype wire

// File: hdl/mul_lane.sv
// zero-skipping shift-add lane, low width bits of an unsigned product
// busy from start until ack, at least popcount(b)+3 cycles
// result and tag stay stable while done until the ack strobe

`default_nettype none

module mul_lane #(
  parameter int width     = mul_pkg::default_width,
  parameter int tag_width = mul_pkg::default_tag_width
) (
  input  logic                 clk,
  input  logic                 reset,

  // from dispatcher, operands shared by all lanes
  input  logic                 start,
  input  logic [width-1:0]     op_a,
  input  logic [width-1:0]     op_b,
  input  logic [tag_width-1:0] op_tag,

  // from collector
  input  logic                 ack,

  output logic                 lane_idle,
  output logic                 lane_done,
  output logic [width-1:0]     lane_product,
  output logic [tag_width-1:0] lane_tag
);

  // one extra bit so that a shift of width fits
  localparam int sh_w = $clog2(width) + 1;

  mul_pkg::lane_state_t state;
  mul_pkg::lane_state_t state_next;

  logic [width-1:0]     a_reg;
  logic [width-1:0]     b_reg;
  logic [width-1:0]     acc;
  logic [tag_width-1:0] tag_reg;

  logic [sh_w-1:0]      shift_amt;
  logic [sh_w-1:0]      step;
  logic [width-1:0]     addend;
  logic                 b_zero;

  // ==========================================================================
  // control
  // ==========================================================================

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= mul_pkg::idle;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      mul_pkg::idle: begin
        if (start) begin
          state_next = mul_pkg::calc;
        end
      end
      // b empty means the last bit went in on the previous edge
      mul_pkg::calc: begin
        if (b_zero) begin
          state_next = mul_pkg::done;
        end
      end
      mul_pkg::done: begin
        if (ack) begin
          state_next = mul_pkg::idle;
        end
      end
      default: state_next = mul_pkg::idle;
    endcase
  end

  assign lane_idle = (state == mul_pkg::idle);
  assign lane_done = (state == mul_pkg::done);

  // ==========================================================================
  // datapath
  // ==========================================================================

  assign b_zero = (b_reg == '0);

  // lowest set bit of b, scanned from the top so the lowest one sticks
  always_comb begin
    shift_amt = '0;
    for (int i = width - 1; i >= 0; i--) begin
      if (b_reg[i]) begin
        shift_amt = sh_w'(i);
      end
    end
  end

  // skip past the bit just used
  assign step   = shift_amt + sh_w'(1);
  assign addend = a_reg << shift_amt;

  always_ff @(posedge clk) begin
    if (start) begin
      a_reg   <= op_a;
      b_reg   <= op_b;
      acc     <= '0;
      tag_reg <= op_tag;
    end else if (state == mul_pkg::calc && !b_zero) begin
      acc   <= acc + addend;
      a_reg <= a_reg << step;
      b_reg <= b_reg >> step;
    end
  end

  assign lane_product = acc;
  assign lane_tag     = tag_reg;

  // ==========================================================================
  // checks
  // ==========================================================================

  // dispatcher must only start a lane it saw idle
  start_in_idle_a : assert property (
    @(posedge clk) disable iff (reset)
    start |-> state == mul_pkg::idle
  );

  // collector must only ack a lane holding a result
  ack_in_done_a : assert property (
    @(posedge clk) disable iff (reset)
    ack |-> state == mul_pkg::done
  );

endmodule

`default_nettype wire

// File: hdl/mul_collect.sv
// result collector, one product out per cycle, lowest done lane first
// ack is combinational, the lane leaves done on the same edge as out_valid

`default_nettype none

module mul_collect #(
  parameter int width     = mul_pkg::default_width,
  parameter int lanes     = mul_pkg::default_lanes,
  parameter int tag_width = mul_pkg::default_tag_width
) (
  input  logic                             clk,
  input  logic                             reset,

  // finished lanes
  input  logic [lanes-1:0]                 lane_done,
  input  logic [lanes-1:0][width-1:0]      lane_product,
  input  logic [lanes-1:0][tag_width-1:0]  lane_tag,
  output logic [lanes-1:0]                 ack,

  // result strobe to outside
  output logic                             out_valid,
  output logic [width-1:0]                 out_product,
  output logic [tag_width-1:0]             out_tag
);

  logic                 any_done;
  logic [width-1:0]     sel_product;
  logic [tag_width-1:0] sel_tag;

  // ==========================================================================
  // arbitration
  // ==========================================================================

  // fixed priority, lowest index
  // a lane waits at most lanes cycles since each higher one leaves once served
  assign ack      = lane_done & (~lane_done + lanes'(1));
  assign any_done = |lane_done;

  // one-hot mux on the acked lane
  always_comb begin
    sel_product = '0;
    sel_tag     = '0;
    for (int i = 0; i < lanes; i++) begin
      if (ack[i]) begin
        sel_product = lane_product[i];
        sel_tag     = lane_tag[i];
      end
    end
  end

  // ==========================================================================
  // output register
  // ==========================================================================

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= any_done;
    end
  end

  // payload only loads when a result is taken
  always_ff @(posedge clk) begin
    if (any_done) begin
      out_product <= sel_product;
      out_tag     <= sel_tag;
    end
  end

  // ==========================================================================
  // checks
  // ==========================================================================

  // single grant, and never to a lane without a result
  ack_onehot_done_a : assert property (
    @(posedge clk) disable iff (reset)
    $onehot0(ack) && ((ack & ~lane_done) == '0)
  );

endmodule

`default_nettype wire

// File: hdl/mul_array.sv
// multiply unit top, lanes iterative multipliers behind one dispatcher
// results may leave out of order, in_tag must be unique while in flight
// no back-pressure on either side, overflow requests are dropped

`default_nettype none

module mul_array #(
  parameter int width     = mul_pkg::default_width,
  parameter int lanes     = mul_pkg::default_lanes,
  parameter int tag_width = mul_pkg::default_tag_width
) (
  input  logic                 clk,
  input  logic                 reset,

  input  logic                 in_valid,
  input  logic [width-1:0]     in_a,
  input  logic [width-1:0]     in_b,
  input  logic [tag_width-1:0] in_tag,

  output logic                 out_valid,
  output logic [width-1:0]     out_product,
  output logic [tag_width-1:0] out_tag,

  output logic [7:0]           drop_count
);

  // ==========================================================================
  // internal buses
  // ==========================================================================

  // dispatcher to lanes
  logic [lanes-1:0]                start;
  logic [width-1:0]                op_a;
  logic [width-1:0]                op_b;
  logic [tag_width-1:0]            op_tag;
  logic [lanes-1:0]                lane_idle;

  // lanes to collector
  logic [lanes-1:0]                lane_done;
  logic [lanes-1:0][width-1:0]     lane_product;
  logic [lanes-1:0][tag_width-1:0] lane_tag;
  logic [lanes-1:0]                ack;

  mul_dispatch #(
    .width     (width),
    .lanes     (lanes),
    .tag_width (tag_width)
  ) mul_dispatch_i (
    .clk        (clk),
    .reset      (reset),
    .in_valid   (in_valid),
    .in_a       (in_a),
    .in_b       (in_b),
    .in_tag     (in_tag),
    .lane_idle  (lane_idle),
    .start      (start),
    .op_a       (op_a),
    .op_b       (op_b),
    .op_tag     (op_tag),
    .drop_count (drop_count)
  );

  // identical lanes, each sees only its own start and ack bit
  for (genvar i = 0; i < lanes; i++) begin : g_lane
    mul_lane #(
      .width     (width),
      .tag_width (tag_width)
    ) mul_lane_i (
      .clk          (clk),
      .reset        (reset),
      .start        (start[i]),
      .op_a         (op_a),
      .op_b         (op_b),
      .op_tag       (op_tag),
      .ack          (ack[i]),
      .lane_idle    (lane_idle[i]),
      .lane_done    (lane_done[i]),
      .lane_product (lane_product[i]),
      .lane_tag     (lane_tag[i])
    );
  end

  mul_collect #(
    .width     (width),
    .lanes     (lanes),
    .tag_width (tag_width)
  ) mul_collect_i (
    .clk          (clk),
    .reset        (reset),
    .lane_done    (lane_done),
    .lane_product (lane_product),
    .lane_tag     (lane_tag),
    .ack          (ack),
    .out_valid    (out_valid),
    .out_product  (out_product),
    .out_tag      (out_tag)
  );

endmodule

`default_nettype wire

// File: testbench/mul_array_tb.sv
// testbench for mul_array with 4 lanes, stimulus from testbench/mul_testdata.txt
// run from the project root so the data file path resolves
// data file tags must not repeat while that request is still in flight

`default_nettype none

module mul_array_tb;

  localparam int width       = 32;
  localparam int lanes       = 4;
  localparam int tag_width   = 4;
  localparam int tag_count   = 1 << tag_width;
  localparam int drain_limit = 2000;

  logic                 clk;
  logic                 reset;
  logic                 in_valid;
  logic [width-1:0]     in_a;
  logic [width-1:0]     in_b;
  logic [tag_width-1:0] in_tag;
  logic                 out_valid;
  logic [width-1:0]     out_product;
  logic [tag_width-1:0] out_tag;
  logic [7:0]           drop_count;

  // ==========================================================================
  // scoreboard, one slot per tag
  // ==========================================================================

  // issued side written by stimulus, returned side by the monitor
  logic [width-1:0] expected_product [tag_count];
  int               issued [tag_count];
  int               returned [tag_count];
  int               issued_total;
  int               returned_total;
  int               expected_drops;

  mul_array #(
    .width     (width),
    .lanes     (lanes),
    .tag_width (tag_width)
  ) mul_array_i (
    .clk         (clk),
    .reset       (reset),
    .in_valid    (in_valid),
    .in_a        (in_a),
    .in_b        (in_b),
    .in_tag      (in_tag),
    .out_valid   (out_valid),
    .out_product (out_product),
    .out_tag     (out_tag),
    .drop_count  (drop_count)
  );

  // period 4
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ==========================================================================
  // helpers
  // ==========================================================================

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] expected);
    if (got !== expected) begin
      $display("ERROR at time %0t: %s is %0h, expected %0h", $time, what, got, expected);
      $display("CHECKS FAILED");
      $fatal(1);
    end
  endtask

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  // one-cycle request strobe, driven on the falling edge
  task automatic drive_request(input logic [width-1:0] a, input logic [width-1:0] b,
                               input logic [tag_width-1:0] tag);
    @(negedge clk);
    in_valid = 1'b1;
    in_a     = a;
    in_b     = b;
    in_tag   = tag;
  endtask

  task automatic drive_idle(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      in_valid = 1'b0;
    end
  endtask

  // quiet unit after reset, every lane idle, nothing started or acked
  task automatic check_reset_state();
    repeat (10) begin
      @(negedge clk);
      check_value("out_valid", out_valid, 1'b0);
      check_value("drop_count", drop_count, 8'd0);
      check_value("start", mul_array_i.start, '0);
      check_value("ack", mul_array_i.ack, '0);
      check_value("lane_done", mul_array_i.lane_done, '0);
      check_value("lane 0 state", mul_array_i.g_lane[0].mul_lane_i.state, mul_pkg::idle);
      check_value("lane 1 state", mul_array_i.g_lane[1].mul_lane_i.state, mul_pkg::idle);
      check_value("lane 2 state", mul_array_i.g_lane[2].mul_lane_i.state, mul_pkg::idle);
      check_value("lane 3 state", mul_array_i.g_lane[3].mul_lane_i.state, mul_pkg::idle);
    end
  endtask

  // sampled on the falling edge, clear of the monitor's updates
  task automatic wait_for_drain();
    int waited;
    waited = 0;
    while (returned_total != issued_total && waited < drain_limit) begin
      @(negedge clk);
      waited++;
    end
    if (returned_total != issued_total) begin
      stop_run($sformatf("timeout: %0d results still missing after %0d cycles",
                         issued_total - returned_total, drain_limit));
    end
  endtask

  // ==========================================================================
  // output monitor
  // ==========================================================================

  // flops update by NBA, so this sees the value held through the last cycle
  always @(posedge clk) begin
    if (!reset && out_valid) begin
      if (returned[out_tag] == issued[out_tag]) begin
        stop_run($sformatf("result with tag %0d at time %0t matches no pending request",
                           out_tag, $time));
      end
      check_value($sformatf("out_product for tag %0d", out_tag), out_product,
                  expected_product[out_tag]);
      returned[out_tag] = returned[out_tag] + 1;
      returned_total    = returned_total + 1;
    end
  end

  // ==========================================================================
  // stimulus
  // ==========================================================================

  initial begin
    int                   fd;
    int                   n;
    string                line;
    logic [width-1:0]     a;
    logic [width-1:0]     b;
    logic [width-1:0]     product;
    logic [31:0]          tag_word;
    int                   gap;
    int                   drop_flag;
    logic [tag_width-1:0] tag;

    reset          = 1'b1;
    in_valid       = 1'b0;
    in_a           = '0;
    in_b           = '0;
    in_tag         = '0;
    issued_total   = 0;
    expected_drops = 0;

    repeat (4) @(negedge clk);
    reset = 1'b0;
    check_reset_state();

    fd = $fopen("testbench/mul_testdata.txt", "r");
    if (fd == 0) begin
      stop_run("could not open testbench/mul_testdata.txt");
    end

    while (!$feof(fd)) begin
      line = "";
      n    = $fgets(line, fd);
      // skip blank and comment lines
      if (n > 1 && line.getc(0) != "#") begin
        n = $sscanf(line, "%h %h %h %d %h %d", a, b, tag_word, gap, product, drop_flag);
        if (n != 6) begin
          stop_run({"malformed line in test data: ", line});
        end
        tag = tag_word[tag_width-1:0];
        if (issued[tag] != returned[tag]) begin
          stop_run($sformatf("test data reuses tag %0d while it is still pending", tag));
        end
        // a dropped request never enters the scoreboard
        if (drop_flag != 0) begin
          expected_drops++;
        end else begin
          expected_product[tag] = product;
          issued[tag]           = issued[tag] + 1;
          issued_total++;
        end
        drive_request(a, b, tag);
        drive_idle(gap);
      end
    end
    $fclose(fd);
    drive_idle(1);

    wait_for_drain();
    // late strays or dropped tags would still hit the monitor here
    drive_idle(20);
    check_value("drop_count", drop_count, expected_drops);

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/mul_testdata.txt
# columns: a b tag (hex), idle gap in cycles (decimal), low product (hex), drop flag 0 or 1
# a line with drop flag 1 must find every lane busy, its product column is not used
# single requests, far apart
00000005 00000000 0 45 00000000 0
00000000 12345678 1 45 00000000 0
12345678 00000001 2 45 12345678 0
00000003 ffffffff 3 45 fffffffd 0
ffffffff ffffffff 4 45 00000001 0
80000000 00000002 5 45 00000000 0
0000ffff 0000ffff 6 45 fffe0001 0
00010000 00010000 7 45 00000000 0
00012345 00000010 8 45 00123450 0
deadbeef 00000100 9 45 adbeef00 0
00000007 00000006 a 45 0000002a 0
ffffffff 00000002 b 45 fffffffe 0
00001000 00001000 c 45 01000000 0
80000001 80000001 d 45 00000001 0
00000064 000003e8 e 45 000186a0 0
# groups of four back to back, sparse and dense b, results out of order
00000002 ffffffff 0 0 fffffffe 0
00000011 00000001 1 1 00000011 0
00000100 00000101 2 2 00010100 0
00000003 00000000 3 50 00000000 0
0000000f 0f0f0f0f 4 0 e1e1e1e1 0
12345678 00000010 5 0 23456780 0
00000005 aaaaaaaa 6 2 55555552 0
00000009 00000003 7 50 0000001b 0
fffffffe 00000003 8 1 fffffffa 0
00000001 80000000 9 0 80000000 0
00001234 ffff0000 a 0 edcc0000 0
00000002 7fffffff b 50 fffffffe 0
00000003 00000005 c 0 0000000f 0
00000004 00000005 d 0 00000014 0
00000005 00000005 e 0 00000019 0
00000006 00000005 f 50 0000001e 0
# identical b on consecutive cycles, then popcounts 3,2 and 3,2,1 finishing together
00000007 00000011 0 0 00000077 0
00000008 00000011 1 50 00000088 0
00000003 00000007 2 0 00000015 0
00000004 00000003 3 50 0000000c 0
00000010 00000070 4 0 00000700 0
00000010 00000300 5 0 00003000 0
00000010 00004000 6 50 00040000 0
# bursts of five, the fifth finds no idle lane
00000002 00000001 7 0 00000002 0
00000003 00000001 8 0 00000003 0
00000004 00000001 9 0 00000004 0
00000005 00000001 a 0 00000005 0
00000006 00000001 b 50 00000006 1
00000001 0000000f c 0 0000000f 0
00000002 0000000f d 0 0000001e 0
00000003 0000000f e 0 0000002d 0
00000004 0000000f f 0 0000003c 0
00000005 0000000f 0 50 0000004b 1
# recovery after the drops
00000003 00000003 1 10 00000009 0

// File: all.f
hdl/mul_pkg.sv
hdl/mul_dispatch.sv
hdl/mul_lane.sv
hdl/mul_collect.sv
hdl/mul_array.sv
testbench/mul_array_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the multiply unit testbench with verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module mul_array_tb \
  -o mul_array_sim > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/mul_array_sim > sim.log 2>&1
cat sim.log
grep -q "CHECKS FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "ALL CHECKS PASSED" sim.log || { echo "simulation ended without a pass"; exit 1; }
echo "simulation passed"
